// File: all.f
verilog/bus_pkg.sv
verilog/perf_pkg.sv
verilog/mem_target.sv
verilog/resp_fifo.sv
verilog/bus_snoop.sv
verilog/perf_top.sv
dv/clk_gen.sv
dv/tb_perf_top.sv

// File: dv/clk_gen.sv
`timescale 1ns/1ps

module clk_gen #(
    parameter int PERIOD_NS  = 4,
    parameter int RST_CYCLES = 5
) (
    output logic clk_o,
    output logic rst_o
);

    // Free-running clock starting low at time zero
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Reset high for the first cycles and released on a rising edge
    initial begin
        rst_o = 1'b1;
        repeat (RST_CYCLES) @(posedge clk_o);
        rst_o <= 1'b0;
    end

endmodule

// File: dv/tb_perf_top.sv
`timescale 1ns/1ps

module tb_perf_top;

    import bus_pkg::*;
    import perf_pkg::*;

    //////////////////////////////////////////////////
    // Run length and limits
    //////////////////////////////////////////////////

    localparam int CLK_PERIOD_NS = 4;
    localparam int RST_CYCLES    = 5;
    // Mixed traffic length
    localparam int MIX_OPS       = 60;
    // Longest wait for one request handshake
    localparam int ACCEPT_MAX    = 64;
    // Longest wait for outstanding responses
    localparam int DRAIN_MAX     = 64;
    // Cycles a blocked request is offered before it counts as refused
    localparam int BLOCK_WAIT    = 8;
    // Cycle budget of all tests together
    localparam int TEST_CYCLES   = 2 * RST_CYCLES + 6 * MEM_DEPTH + 4 * MIX_OPS
                                 + 8 * (FIFO_DEPTH + 2) + 4 * DRAIN_MAX;

    typedef enum logic [1:0] {RDY_HIGH, RDY_RANDOM, RDY_LOW} rdy_mode_e;

    logic  clk;
    logic  rst;
    // Request channel
    logic  req_valid;
    logic  req_write;
    addr_t req_addr;
    data_t req_wdata;
    logic  req_ready;
    // Response channel
    logic  rsp_valid;
    logic  rsp_write;
    data_t rsp_rdata;
    logic  rsp_ready = 1'b1;
    // Snoop counters
    cnt_t  req_count;
    cnt_t  done_count;
    cnt_t  stall_count;

    // Reference memory and responses still owed
    data_t           model_mem [MEM_DEPTH];
    logic [DATA_W:0] exp_q [$];
    // Events seen at the DUT ports
    cnt_t            mon_req_cnt = '0;
    cnt_t            mon_done_cnt = '0;
    cnt_t            mon_stall_cnt = '0;

    int        seed = 70;
    rdy_mode_e rsp_mode = RDY_HIGH;
    logic      next_ready = 1'b1;
    string     cur_test = "none";
    int        test_errors = 0;
    int        total_errors = 0;
    int        tests_run = 0;
    int        tests_failed = 0;

    clk_gen #(.PERIOD_NS(CLK_PERIOD_NS), .RST_CYCLES(RST_CYCLES)) clk_gen_i (
        .clk_o (clk),
        .rst_o (rst)
    );

    perf_top perf_top_i (
        .clk_i         (clk),
        .rst_ni        (rst),
        .req_valid_i   (req_valid),
        .req_write_i   (req_write),
        .req_addr_i    (req_addr),
        .req_wdata_i   (req_wdata),
        .req_ready_o   (req_ready),
        .rsp_valid_o   (rsp_valid),
        .rsp_write_o   (rsp_write),
        .rsp_rdata_o   (rsp_rdata),
        .rsp_ready_i   (rsp_ready),
        .req_count_o   (req_count),
        .done_count_o  (done_count),
        .stall_count_o (stall_count)
    );

    //////////////////////////////////////////////////
    // Checking helpers
    //////////////////////////////////////////////////

    task automatic expect_equal(input string what, input logic [63:0] exp_val,
                                input logic [63:0] act_val);
        assert (act_val === exp_val) else begin
            $display("** Error [%s] %s: expected 0x%0h, actual 0x%0h",
                     cur_test, what, exp_val, act_val);
            test_errors++;
        end
    endtask

    task automatic report_failure(input string msg);
        $display("[%s] %s", cur_test, msg);
        test_errors++;
    endtask

    task automatic begin_test(input string name);
        cur_test    = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        tests_run++;
        total_errors += test_errors;
        if (test_errors == 0) begin
            $display("test %-16s ok", cur_test);
        end else begin
            tests_failed++;
            $display("test %-16s FAILED with %0d errors", cur_test, test_errors);
        end
    endtask

    //////////////////////////////////////////////////
    // Master side drivers
    //////////////////////////////////////////////////

    // Next ready value picked at the falling edge, applied at the rising one
    always @(negedge clk) begin
        logic [31:0] rnd;
        case (rsp_mode)
            RDY_HIGH: next_ready = 1'b1;
            RDY_RANDOM: begin
                rnd = $random(seed);
                next_ready = rnd[0];
            end
            default: next_ready = 1'b0;
        endcase
    end

    always @(posedge clk) begin
        rsp_ready <= next_ready;
    end

    // Called right after a rising edge
    task automatic drive_req(input logic write, input addr_t addr, input data_t wdata);
        req_valid <= 1'b1;
        req_write <= write;
        req_addr  <= addr;
        req_wdata <= wdata;
    endtask

    task automatic drop_req();
        req_valid <= 1'b0;
    endtask

    // Returns on the edge of the handshake
    task automatic wait_accept(input int max_cycles, output bit accepted);
        int cycles;
        accepted = 1'b0;
        cycles   = 0;
        while (!accepted && cycles < max_cycles) begin
            @(posedge clk);
            accepted = req_ready;
            cycles++;
        end
    endtask

    task automatic issue(input logic write, input addr_t addr, input data_t wdata);
        bit ok;
        drive_req(write, addr, wdata);
        wait_accept(ACCEPT_MAX, ok);
        assert (ok) else report_failure($sformatf(
            "request to address %0d not accepted within %0d cycles", addr, ACCEPT_MAX));
    endtask

    //////////////////////////////////////////////////
    // Port monitor and response check
    //////////////////////////////////////////////////

    always @(posedge clk) begin
        logic [DATA_W:0] head;
        if (!rst) begin
            // Request handshake updates the model at acceptance
            if (req_valid && req_ready) begin
                mon_req_cnt++;
                if (req_write) begin
                    model_mem[req_addr] = req_wdata;
                    exp_q.push_back({1'b1, {DATA_W{1'b0}}});
                end else begin
                    exp_q.push_back({1'b0, model_mem[req_addr]});
                end
            end
            // Response handshake checked against the oldest request
            if (rsp_valid && rsp_ready) begin
                assert (exp_q.size() != 0) else
                    report_failure("response arrived with no request outstanding");
                if (exp_q.size() != 0) begin
                    head = exp_q.pop_front();
                    expect_equal($sformatf("response %0d write flag", mon_done_cnt),
                                 head[DATA_W], rsp_write);
                    expect_equal($sformatf("response %0d data", mon_done_cnt),
                                 head[DATA_W-1:0], rsp_rdata);
                end
                mon_done_cnt++;
            end
            // Stalled response
            if (rsp_valid && !rsp_ready) begin
                mon_stall_cnt++;
            end
        end
    end

    // Wait for all responses, then compare counters one cycle later
    task automatic finish_traffic();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (exp_q.size() != 0 && cycles < DRAIN_MAX) begin
            @(negedge clk);
            cycles++;
        end
        assert (exp_q.size() == 0) else report_failure($sformatf(
            "%0d responses never arrived", exp_q.size()));
        @(posedge clk);
        @(negedge clk);
        expect_equal("rsp_valid_o after drain", 1'b0, rsp_valid);
        expect_equal("req_count_o", mon_req_cnt, req_count);
        expect_equal("done_count_o", mon_done_cnt, done_count);
        expect_equal("stall_count_o", mon_stall_cnt, stall_count);
    endtask

    //////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////

    task automatic check_idle(input string tag);
        expect_equal({"rsp_valid_o ", tag}, 1'b0, rsp_valid);
        expect_equal({"req_count_o ", tag}, '0, req_count);
        expect_equal({"done_count_o ", tag}, '0, done_count);
        expect_equal({"stall_count_o ", tag}, '0, stall_count);
    endtask

    task automatic run_reset();
        begin_test("reset");
        // First falling edge follows the first reset edge
        @(negedge clk);
        while (rst) begin
            check_idle("in reset");
            @(negedge clk);
        end
        check_idle("after reset");
        expect_equal("req_ready_o after reset", 1'b1, req_ready);
        end_test();
    endtask

    task automatic run_data_integrity();
        logic [31:0] rnd;
        addr_t       start;
        addr_t       stride;
        begin_test("data_integrity");
        @(posedge clk);
        rsp_mode = RDY_HIGH;
        for (int i = 0; i < MEM_DEPTH; i++) begin
            rnd = $random(seed);
            issue(1'b1, addr_t'(i), rnd);
        end
        // Odd stride visits every address once
        rnd    = $random(seed);
        start  = rnd[ADDR_W-1:0];
        stride = {rnd[2*ADDR_W-2:ADDR_W], 1'b1};
        for (int i = 0; i < MEM_DEPTH; i++) begin
            issue(1'b0, start + addr_t'(i) * stride, '0);
        end
        drop_req();
        finish_traffic();
        end_test();
    endtask

    task automatic run_ordering();
        logic [31:0] rnd;
        begin_test("ordering");
        @(posedge clk);
        rsp_mode = RDY_RANDOM;
        for (int i = 0; i < MIX_OPS; i++) begin
            rnd = $random(seed);
            issue(rnd[0], rnd[ADDR_W:1], $random(seed));
            // Idle gap now and then
            if (rnd[9:8] == 2'b00) begin
                drop_req();
                @(posedge clk);
            end
        end
        drop_req();
        finish_traffic();
        end_test();
    endtask

    task automatic run_fill_drain();
        logic [31:0] rnd;
        int          accepted;
        bit          ok;
        begin_test("fill_drain");
        @(posedge clk);
        rsp_mode = RDY_LOW;
        // Ready low at the DUT before the first offer
        repeat (2) @(posedge clk);
        accepted = 0;
        ok       = 1'b1;
        while (ok && accepted <= FIFO_DEPTH + 1) begin
            rnd = $random(seed);
            drive_req(rnd[0], rnd[ADDR_W:1], $random(seed));
            wait_accept(BLOCK_WAIT, ok);
            if (ok) begin
                accepted++;
            end
        end
        assert (!ok) else report_failure("req_ready_o stayed high with the FIFO full");
        assert (accepted <= FIFO_DEPTH + 1) else begin
            $display("** Error [%s] accepted while blocked: expected at most %0d, actual %0d",
                     cur_test, FIFO_DEPTH + 1, accepted);
            test_errors++;
        end
        @(negedge clk);
        expect_equal("req_ready_o with the FIFO full", 1'b0, req_ready);
        expect_equal("rsp_valid_o with responses held", 1'b1, rsp_valid);
        // Release lets the blocked request in and drains everything
        @(posedge clk);
        rsp_mode = RDY_HIGH;
        wait_accept(ACCEPT_MAX, ok);
        assert (ok) else report_failure("blocked request never accepted after release");
        drop_req();
        finish_traffic();
        end_test();
    endtask

    //////////////////////////////////////////////////
    // Sequence and watchdog
    //////////////////////////////////////////////////

    initial begin
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        for (int i = 0; i < MEM_DEPTH; i++) begin
            model_mem[i] = '0;
        end
        run_reset();
        run_data_integrity();
        run_ordering();
        run_fill_drain();
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors);
        if (total_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        #(TEST_CYCLES * CLK_PERIOD_NS * 4);
        $display("Watchdog expired after %0d ns, the run did not finish",
                 TEST_CYCLES * CLK_PERIOD_NS * 4);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# Compile and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_perf_top -f all.f -o sim_perf

./obj_dir/sim_perf > "$LOG" 2>&1
cat "$LOG"

if grep -q "FAIL: see errors above" "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi

echo "simulation finished without failure"

// File: verilog/bus_pkg.sv
package bus_pkg;

    //////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////

    // Word address into the register memory
    localparam int ADDR_W = 4;

    // Data word carried on both channels
    localparam int DATA_W = 32;

    //////////////////////////////////////////////////
    // Depths
    //////////////////////////////////////////////////

    // One memory word per address
    localparam int MEM_DEPTH = 2 ** ADDR_W;

    // Response FIFO entries between target and master
    localparam int FIFO_DEPTH = 4;

    //////////////////////////////////////////////////
    // Types
    //////////////////////////////////////////////////

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;

endpackage

// File: verilog/bus_snoop.sv
`timescale 1ns/1ps

module bus_snoop (
    input  logic           clk_i,
    input  logic           rst_ni,
    // Master-side request
    input  logic           req_valid_i,
    input  logic           req_write_i,
    input  bus_pkg::addr_t req_addr_i,
    input  bus_pkg::data_t req_wdata_i,
    output logic           req_ready_o,
    // Target-side request
    output logic           req_valid_o,
    output logic           req_write_o,
    output bus_pkg::addr_t req_addr_o,
    output bus_pkg::data_t req_wdata_o,
    input  logic           req_ready_i,
    // Buffer-side response
    input  logic           rsp_valid_i,
    input  logic           rsp_write_i,
    input  bus_pkg::data_t rsp_rdata_i,
    output logic           rsp_ready_o,
    // Master-side response
    output logic           rsp_valid_o,
    output logic           rsp_write_o,
    output bus_pkg::data_t rsp_rdata_o,
    input  logic           rsp_ready_i,
    // Performance counters
    output perf_pkg::cnt_t req_count_o,
    output perf_pkg::cnt_t done_count_o,
    output perf_pkg::cnt_t stall_count_o
);

    import perf_pkg::*;

    cnt_t req_cnt_q;
    cnt_t done_cnt_q;
    cnt_t stall_cnt_q;

    //////////////////////////////////////////////////
    // Pass-through with no added latency
    //////////////////////////////////////////////////

    assign req_valid_o = req_valid_i;
    assign req_write_o = req_write_i;
    assign req_addr_o  = req_addr_i;
    assign req_wdata_o = req_wdata_i;
    assign req_ready_o = req_ready_i;

    assign rsp_valid_o = rsp_valid_i;
    assign rsp_write_o = rsp_write_i;
    assign rsp_rdata_o = rsp_rdata_i;
    assign rsp_ready_o = rsp_ready_i;

    //////////////////////////////////////////////////
    // Event counters
    //////////////////////////////////////////////////

    // All three wrap, cleared only by reset
    always_ff @(posedge clk_i) begin
        if (rst_ni) begin
            req_cnt_q   <= '0;
            done_cnt_q  <= '0;
            stall_cnt_q <= '0;
        end else begin
            // Request handshake
            if (req_valid_i && req_ready_i) begin
                req_cnt_q <= req_cnt_q + 1'b1;
            end
            // Response handshake
            if (rsp_valid_i && rsp_ready_i) begin
                done_cnt_q <= done_cnt_q + 1'b1;
            end
            // Response waiting on the master
            if (rsp_valid_i && !rsp_ready_i) begin
                stall_cnt_q <= stall_cnt_q + 1'b1;
            end
        end
    end

    assign req_count_o   = req_cnt_q;
    assign done_count_o  = done_cnt_q;
    assign stall_count_o = stall_cnt_q;

    a_valid_pass: assert property (
        @(posedge clk_i) (req_valid_o == req_valid_i) && (rsp_valid_o == rsp_valid_i)
    ) else $error("bus_snoop: forwarded valid differs from input");

endmodule

// File: verilog/mem_target.sv
`timescale 1ns/1ps

module mem_target (
    input  logic           clk_i,
    input  logic           rst_ni,
    // Request channel from the snoop
    input  logic           req_valid_i,
    input  logic           req_write_i,
    input  bus_pkg::addr_t req_addr_i,
    input  bus_pkg::data_t req_wdata_i,
    output logic           req_ready_o,
    // Response toward the FIFO
    output logic           out_valid_o,
    output logic           out_write_o,
    output bus_pkg::data_t out_rdata_o,
    input  logic           out_ready_i
);

    import bus_pkg::*;

    // Register memory
    data_t mem_q [MEM_DEPTH];

    // One-entry output register
    logic  out_valid_q;
    logic  out_write_q;
    data_t out_rdata_q;

    // Handshakes on both sides
    logic  req_fire;
    logic  out_fire;

    //////////////////////////////////////////////////
    // Handshake logic
    //////////////////////////////////////////////////

    assign out_fire = out_valid_q && out_ready_i;

    // Free slot, or slot draining this cycle
    assign req_ready_o = !out_valid_q || out_ready_i;
    assign req_fire    = req_valid_i && req_ready_o;

    //////////////////////////////////////////////////
    // Memory array
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (rst_ni) begin
            // Memory starts out all zero
            for (int i = 0; i < MEM_DEPTH; i++) begin
                mem_q[i] <= '0;
            end
        end else if (req_fire && req_write_i) begin
            mem_q[req_addr_i] <= req_wdata_i;
        end
    end

    //////////////////////////////////////////////////
    // Output register
    //////////////////////////////////////////////////

    // Valid flag
    always_ff @(posedge clk_i) begin
        if (rst_ni) begin
            out_valid_q <= 1'b0;
        end else if (req_fire) begin
            out_valid_q <= 1'b1;
        end else if (out_fire) begin
            out_valid_q <= 1'b0;
        end
    end

    // Payload loaded on acceptance
    always_ff @(posedge clk_i) begin
        if (req_fire) begin
            out_write_q <= req_write_i;
            // Write response carries zero data
            out_rdata_q <= req_write_i ? '0 : mem_q[req_addr_i];
        end
    end

    assign out_valid_o = out_valid_q;
    assign out_write_o = out_write_q;
    assign out_rdata_o = out_rdata_q;

    // A held response survives until the FIFO takes it
    a_out_hold: assert property (
        @(posedge clk_i) disable iff (rst_ni)
        (out_valid_q && !out_ready_i)
            |=> (out_valid_q && $stable(out_write_q) && $stable(out_rdata_q))
    ) else $error("mem_target: held response overwritten");

endmodule

// File: verilog/perf_pkg.sv
package perf_pkg;

    //////////////////////////////////////////////////
    // Counters
    //////////////////////////////////////////////////

    // Wide enough that wrap is rare in practice
    localparam int CNT_W = 32;

    // Counter value that wraps on overflow
    typedef logic [CNT_W-1:0] cnt_t;

endpackage

// File: verilog/perf_top.sv
`timescale 1ns/1ps

module perf_top (
    input  logic           clk_i,
    input  logic           rst_ni,
    // Request channel from the master
    input  logic           req_valid_i,
    input  logic           req_write_i,
    input  bus_pkg::addr_t req_addr_i,
    input  bus_pkg::data_t req_wdata_i,
    output logic           req_ready_o,
    // Response channel to the master
    output logic           rsp_valid_o,
    output logic           rsp_write_o,
    output bus_pkg::data_t rsp_rdata_o,
    input  logic           rsp_ready_i,
    // Snoop counters
    output perf_pkg::cnt_t req_count_o,
    output perf_pkg::cnt_t done_count_o,
    output perf_pkg::cnt_t stall_count_o
);

    import bus_pkg::*;

    // Snoop to target
    logic  tgt_req_valid;
    logic  tgt_req_write;
    addr_t tgt_req_addr;
    data_t tgt_req_wdata;
    logic  tgt_req_ready;

    // Target to FIFO with the write flag on top of the data
    logic              out_valid;
    logic              out_write;
    data_t             out_rdata;
    logic              out_ready;
    logic [DATA_W:0]   fifo_wr_data;

    // FIFO to snoop
    logic              fifo_rd_valid;
    logic [DATA_W:0]   fifo_rd_data;
    logic              fifo_rd_ready;

    assign fifo_wr_data = {out_write, out_rdata};

    bus_snoop bus_snoop_i (
        .clk_i, .rst_ni,
        .req_valid_i, .req_write_i, .req_addr_i, .req_wdata_i, .req_ready_o,
        .req_valid_o (tgt_req_valid), .req_write_o (tgt_req_write),
        .req_addr_o  (tgt_req_addr),  .req_wdata_o (tgt_req_wdata),
        .req_ready_i (tgt_req_ready),
        .rsp_valid_i (fifo_rd_valid), .rsp_write_i (fifo_rd_data[DATA_W]),
        .rsp_rdata_i (fifo_rd_data[DATA_W-1:0]), .rsp_ready_o (fifo_rd_ready),
        .rsp_valid_o, .rsp_write_o, .rsp_rdata_o, .rsp_ready_i,
        .req_count_o, .done_count_o, .stall_count_o
    );

    mem_target mem_target_i (
        .clk_i, .rst_ni,
        .req_valid_i (tgt_req_valid), .req_write_i (tgt_req_write),
        .req_addr_i  (tgt_req_addr),  .req_wdata_i (tgt_req_wdata),
        .req_ready_o (tgt_req_ready),
        .out_valid_o (out_valid), .out_write_o (out_write),
        .out_rdata_o (out_rdata), .out_ready_i (out_ready)
    );

    // Response buffer toward the master
    resp_fifo #(.DEPTH(FIFO_DEPTH), .WIDTH(DATA_W + 1)) resp_fifo_i (
        .clk_i, .rst_ni,
        .wr_valid_i (out_valid),     .wr_data_i (fifo_wr_data), .wr_ready_o (out_ready),
        .rd_valid_o (fifo_rd_valid), .rd_data_o (fifo_rd_data), .rd_ready_i (fifo_rd_ready)
    );

endmodule

// File: verilog/resp_fifo.sv
`timescale 1ns/1ps

module resp_fifo #(
    parameter int DEPTH = 4,
    parameter int WIDTH = 33
) (
    input  logic             clk_i,
    input  logic             rst_ni,
    // Write side
    input  logic             wr_valid_i,
    input  logic [WIDTH-1:0] wr_data_i,
    output logic             wr_ready_o,
    // Read side
    output logic             rd_valid_o,
    output logic [WIDTH-1:0] rd_data_o,
    input  logic             rd_ready_i
);

    // Pointer and occupancy widths
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);

    // Entry storage
    logic [WIDTH-1:0] buf_q [DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;

    logic full;
    logic wr_fire;
    logic rd_fire;

    //////////////////////////////////////////////////
    // Status and handshakes
    //////////////////////////////////////////////////

    assign full       = (count_q == FULL_CNT);
    assign rd_valid_o = (count_q != '0);
    assign rd_data_o  = buf_q[rd_ptr_q];

    // When full, a read this cycle frees the slot
    assign wr_ready_o = !full || rd_ready_i;
    assign wr_fire    = wr_valid_i && wr_ready_o;
    assign rd_fire    = rd_valid_o && rd_ready_i;

    //////////////////////////////////////////////////
    // Pointers and occupancy
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            // Pointers wrap at DEPTH rather than at a power of two
            if (wr_fire) begin
                wr_ptr_q <= (wr_ptr_q == LAST_PTR) ? '0 : wr_ptr_q + 1'b1;
            end
            if (rd_fire) begin
                rd_ptr_q <= (rd_ptr_q == LAST_PTR) ? '0 : rd_ptr_q + 1'b1;
            end
            // Simultaneous push and pop leaves count as is
            if (wr_fire && !rd_fire) begin
                count_q <= count_q + 1'b1;
            end else if (rd_fire && !wr_fire) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // Entry write
    always_ff @(posedge clk_i) begin
        if (wr_fire) begin
            buf_q[wr_ptr_q] <= wr_data_i;
        end
    end

    a_count_max: assert property (
        @(posedge clk_i) disable iff (rst_ni) count_q <= FULL_CNT
    ) else $error("resp_fifo: occupancy above DEPTH");

    // Head entry frozen while the reader stalls
    a_rd_stable: assert property (
        @(posedge clk_i) disable iff (rst_ni)
        (rd_valid_o && !rd_ready_i) |=> (rd_valid_o && $stable(rd_data_o))
    ) else $error("resp_fifo: head changed under stall");

endmodule
